// ==== csync_gen.sv ====
// Composite sync generator
// Combines normalized syncs, moving hsync pulses to the line end during vsync
`timescale 1ns/1ps

module csync_gen #(
	parameter int CNT_W = sync_types_pkg::CNT_W_DEFAULT
) (
	input  logic                       clk,
	input  logic                       resetd,
	input  sync_types_pkg::sync_pair_t i_sync,
	output logic                       o_csync
);

	logic             hs_d;
	logic             hs_rise;
	logic             hs_fall;
	logic [CNT_W-1:0] line_cnt;
	logic [CNT_W-1:0] line_len;
	logic [CNT_W-1:0] hs_len;
	logic [CNT_W-1:0] serr_pos;
	logic             hs_term;
	logic             vs_q;

	assign hs_rise = i_sync.hs & ~hs_d;
	assign hs_fall = ~i_sync.hs & hs_d;

	// Where the moved pulse starts, one pulse width before line end
	assign serr_pos = line_len - hs_len;

	//////////////////////////////////////////////////////////
	// Line and pulse measurement
	//////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			line_cnt <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_d <= i_sync.hs;

			// Line starts on the hsync rising edge
			// First cycle of the line counts as one
			if (hs_rise) begin
				line_cnt <= {{(CNT_W-1){1'b0}}, 1'b1};
			end else if (~&line_cnt) begin
				line_cnt <= line_cnt + 1'b1;
			end

			if (hs_rise) begin
				line_len <= line_cnt;
			end

			if (hs_fall) begin
				hs_len <= line_cnt;
			end
		end
	end

	//////////////////////////////////////////////////////////
	// Composite
	//////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_term <= 1'b0;
			vs_q    <= 1'b0;
		end else begin
			vs_q <= i_sync.vs;

			if (!i_sync.vs) begin
				hs_term <= i_sync.hs;
			end else if (hs_rise) begin
				// Serration pulse ends where the next line begins
				hs_term <= 1'b0;
			end else if (line_cnt == serr_pos) begin
				hs_term <= 1'b1;
			end
		end
	end

	// High while active, inverted hsync term inside vsync
	assign o_csync = vs_q ^ hs_term;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the VGA sync testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

TOP=tb_vga_sync
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module "$TOP" -f sim.f -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

// ==== sim.f ====
+incdir+.
sync_types_pkg.sv
vga_cfg_pkg.sv
sync_polarity.sv
csync_gen.sv
vga_sync_out.sv
vga_sync_top.sv
tb_vga_sync.sv

// ==== sync_polarity.sv ====
// Sync polarity normalizer
// Measures both phases of one sync and outputs the shorter one as a high pulse
`timescale 1ns/1ps

module sync_polarity #(
	parameter int CNT_W = sync_types_pkg::CNT_W_DEFAULT
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic             sync_s1;
	logic             sync_s2;
	logic             sync_rise;
	logic             sync_fall;
	logic [CNT_W-1:0] phase_cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             pol;
	logic             sync_q;

	// Edge detect on the sampled input
	assign sync_rise = sync_s1 & ~sync_s2;
	assign sync_fall = ~sync_s1 & sync_s2;

	//////////////////////////////////////////////////////////
	// Phase measurement
	//////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			sync_s1   <= 1'b0;
			sync_s2   <= 1'b0;
			phase_cnt <= '0;
			high_len  <= '0;
			low_len   <= '0;
			pol       <= 1'b0;
		end else begin
			sync_s1 <= i_sync;
			sync_s2 <= sync_s1;

			// Cycles since the last edge, sticks at full scale
			if (sync_rise || sync_fall) begin
				phase_cnt <= '0;
			end else if (~&phase_cnt) begin
				phase_cnt <= phase_cnt + 1'b1;
			end

			// Low phase just ended
			if (sync_rise) begin
				low_len <= phase_cnt;
				pol     <= high_len > phase_cnt;
			end

			// High phase just ended
			if (sync_fall) begin
				high_len <= phase_cnt;
				pol      <= phase_cnt > low_len;
			end
		end
	end

	//////////////////////////////////////////////////////////
	// Normalized output
	//////////////////////////////////////////////////////////

	// Invert when the high phase is the long one
	always_ff @(posedge clk) begin
		if (resetd) begin
			sync_q <= 1'b0;
		end else begin
			sync_q <= i_sync ^ pol;
		end
	end

	assign o_sync = sync_q;

endmodule

// ==== sync_types_pkg.sv ====
// Sync datapath types
// Horizontal/vertical sync pair and default counter sizing

package sync_types_pkg;

	//////////////////////////////////////////////////////////
	// Sync pair
	//////////////////////////////////////////////////////////

	// One horizontal and one vertical sync level
	// Raw polarity at the input, active high once normalized
	typedef struct packed {
		logic hs;
		logic vs;
	} sync_pair_t;

	// Both syncs inactive
	localparam sync_pair_t SYNC_IDLE = '{hs: 1'b0, vs: 1'b0};

	//////////////////////////////////////////////////////////
	// Counter sizing
	//////////////////////////////////////////////////////////

	// Phase and line counters
	// A full line must fit, 16 bits covers any common video timing
	localparam int CNT_W_DEFAULT = 16;

endpackage

// ==== tb_sync_model.svh ====
// Sync path reference model
// Expected sync levels, pseudo-random source and typed compares
`ifndef TB_SYNC_MODEL_SVH
`define TB_SYNC_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference functions
////////////////////////////////////////////////////////////

// Normalized pair at a raster position
// Both pulses sit at the start of the line and of the frame
function automatic sync_types_pkg::sync_pair_t ref_norm(input int x, input int y,
		input int hs_w, input int vs_lines);
	sync_types_pkg::sync_pair_t p;
	p.hs = (x < hs_w);
	p.vs = (y < vs_lines);
	return p;
endfunction

// Composite level, active high
// Inside vsync the hsync pulse moves to the last hs_w cycles of the line
function automatic logic ref_csync(input int x, input int y, input int len,
		input int hs_w, input int vs_lines);
	if (y < vs_lines) begin
		return (x < len - hs_w);
	end
	return (x < hs_w);
endfunction

// Pin levels for a mode, active low
function automatic vga_cfg_pkg::vga_pins_t ref_pins(input sync_types_pkg::sync_pair_t n,
		input logic cs, input vga_cfg_pkg::vga_mode_t m);
	vga_cfg_pkg::vga_pins_t p;
	p.hs_n = ~n.hs;
	p.vs_n = ~n.vs;
	if (m.csync_en) begin
		p.hs_n = ~cs;
		p.vs_n = 1'b1;
	end
	// Disable wins over either sync mode
	if (m.out_dis) begin
		p = '{hs_n: 1'b1, vs_n: 1'b1};
	end
	return p;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] v;
	v = s ^ (s << 13);
	v = v ^ (v >> 17);
	v = v ^ (v << 5);
	return v;
endfunction

////////////////////////////////////////////////////////////
// Compares
////////////////////////////////////////////////////////////

task automatic check_pins(input vga_cfg_pkg::vga_pins_t got,
		input vga_cfg_pkg::vga_pins_t exp, input string what);
	if (got !== exp) begin
		$display("** Error at %0d ns: %s, hs_n/vs_n %b/%b, expected %b/%b",
			$time, what, got.hs_n, got.vs_n, exp.hs_n, exp.vs_n);
		stop_on_failure();
	end
endtask

task automatic check_pair(input sync_types_pkg::sync_pair_t got,
		input sync_types_pkg::sync_pair_t exp, input string what);
	if (got !== exp) begin
		$display("** Error at %0d ns: %s, hs/vs %b/%b, expected %b/%b",
			$time, what, got.hs, got.vs, exp.hs, exp.vs);
		stop_on_failure();
	end
endtask

task automatic check_len(input int got, input int exp, input string what);
	if (got != exp) begin
		$display("** Error at %0d ns: %s, %0d cycles, expected %0d",
			$time, what, got, exp);
		stop_on_failure();
	end
endtask

`endif

// ==== tb_vga_sync.sv ====
// VGA sync path testbench
// Random raster timings in every polarity, checked cycle by cycle against a model
`timescale 1ns/1ps

module tb_vga_sync;

	localparam int CNT_W         = 12;
	localparam int FRAME_TIMEOUT = 2500;

	logic                       clk = 1'b0;
	logic                       resetd;
	sync_types_pkg::sync_pair_t i_sync;
	vga_cfg_pkg::vga_mode_t     i_mode;
	vga_cfg_pkg::vga_pins_t     o_vga;

	// Mode applied with the next stimulus sample
	vga_cfg_pkg::vga_mode_t     mode_req;

	// Active raster timing
	int                         line_len;
	int                         hs_w;
	int                         frame_lines;
	int                         vs_lines;
	sync_types_pkg::sync_pair_t inv;

	// Timing loaded at the next frame start
	int                         nxt_len;
	int                         nxt_hs_w;
	int                         nxt_lines;
	int                         nxt_vs_lines;
	sync_types_pkg::sync_pair_t nxt_inv;
	logic                       cfg_pend;

	int                         x;
	int                         y;
	int                         frame_cnt;
	logic                       gen_on;
	logic                       chk_on;
	int                         hs_low;
	int                         vs_low;
	int                         serr_cnt;
	logic [31:0]                rng;

	// Expected values and their check enables, oldest first
	sync_types_pkg::sync_pair_t norm_q[$];
	logic                       norm_chk_q[$];
	vga_cfg_pkg::vga_pins_t     pins_q[$];
	logic                       pins_chk_q[$];

	task automatic stop_on_failure();
		$display("Finished with errors");
		$fatal(1, "Stopped at first error");
	endtask

	`include "tb_sync_model.svh"

	vga_sync_top #(
		.CNT_W(CNT_W)
	) vga_sync_top_i (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync),
		.i_mode (i_mode),
		.o_vga  (o_vga)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Raster generator
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin : stim_gen
		sync_types_pkg::sync_pair_t nrm;
		logic                       cs;
		#1;
		i_mode = mode_req;
		if (gen_on) begin
			if (x == 0 && y == 0 && cfg_pend) begin
				line_len    = nxt_len;
				hs_w        = nxt_hs_w;
				frame_lines = nxt_lines;
				vs_lines    = nxt_vs_lines;
				inv         = nxt_inv;
				cfg_pend    = 1'b0;
			end
			nrm = ref_norm(x, y, hs_w, vs_lines);
			cs = ref_csync(x, y, line_len, hs_w, vs_lines);
			// Raw polarity on the wire
			i_sync = nrm ^ inv;
			norm_q.push_back(nrm);
			norm_chk_q.push_back(chk_on);
			pins_q.push_back(ref_pins(nrm, cs, i_mode));
			pins_chk_q.push_back(chk_on);
			x++;
			if (x == line_len) begin
				x = 0;
				y++;
				if (y == frame_lines) begin
					y = 0;
					frame_cnt++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output checks
	////////////////////////////////////////////////////////////

	// Normalized pair lags the raw input by 1 cycle, pins by 3
	always @(negedge clk) begin : out_check
		sync_types_pkg::sync_pair_t exp_norm;
		vga_cfg_pkg::vga_pins_t     exp_pins;
		logic                       do_chk;
		if (norm_q.size() > 1) begin
			exp_norm = norm_q.pop_front();
			do_chk = norm_chk_q.pop_front();
			if (do_chk) begin
				check_pair(vga_sync_top_i.norm, exp_norm, "normalized sync pair");
			end
		end
		if (pins_q.size() > 3) begin
			exp_pins = pins_q.pop_front();
			do_chk = pins_chk_q.pop_front();
			if (do_chk) begin
				check_pins(o_vga, exp_pins, "sync pins");
			end
		end
	end

	// Low time of each pin pulse
	always @(negedge clk) begin : low_time
		if (chk_on && !i_mode.csync_en && !i_mode.out_dis) begin
			if (!o_vga.hs_n) begin
				hs_low++;
			end else if (hs_low != 0) begin
				check_len(hs_low, hs_w, "hs_n low time");
				hs_low = 0;
			end
			if (!o_vga.vs_n) begin
				vs_low++;
			end else if (vs_low != 0) begin
				check_len(vs_low, vs_lines * line_len, "vs_n low time");
				vs_low = 0;
			end
		end else if (chk_on && !i_mode.out_dis) begin
			// Serrated line is low for all but one pulse width
			if (!o_vga.hs_n) begin
				hs_low++;
			end else if (hs_low == line_len - hs_w) begin
				serr_cnt++;
				hs_low = 0;
			end else if (hs_low != 0) begin
				check_len(hs_low, hs_w, "composite low time outside vsync");
				hs_low = 0;
			end
		end else begin
			hs_low = 0;
			vs_low = 0;
		end
	end

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	task automatic wait_frames(input int n, input string what);
		int start;
		int cyc;
		start = frame_cnt;
		cyc = 0;
		while (frame_cnt - start < n) begin
			@(posedge clk);
			cyc++;
			if (cyc > n * FRAME_TIMEOUT) begin
				$display("Timeout: %0d frames did not complete during %s", n, what);
				stop_on_failure();
			end
		end
	endtask

	// New random timing, then two whole frames for the polarity to settle
	task automatic new_config(input int pol);
		rng = xorshift32(rng);
		nxt_len = 24 + int'(rng % 40);
		rng = xorshift32(rng);
		nxt_hs_w = 2 + int'(rng % 8);
		rng = xorshift32(rng);
		nxt_lines = 10 + int'(rng % 8);
		rng = xorshift32(rng);
		nxt_vs_lines = 2 + int'(rng % 3);
		nxt_inv.hs = pol[0];
		nxt_inv.vs = pol[1];
		chk_on = 1'b0;
		cfg_pend = 1'b1;
		$display("Line %0d, hsync %0d, frame %0d lines, vsync %0d, inverted hs/vs %b/%b",
			nxt_len, nxt_hs_w, nxt_lines, nxt_vs_lines, pol[0], pol[1]);
		wait_frames(3, "polarity settling");
	endtask

	task automatic check_frames(input int n, input string what);
		serr_cnt = 0;
		chk_on = 1'b1;
		wait_frames(n, what);
		chk_on = 1'b0;
		// One serrated line per vsync line in composite mode
		if (i_mode.csync_en && !i_mode.out_dis) begin
			check_len(serr_cnt, n * vs_lines, "serrated vsync lines");
		end
	endtask

	initial begin : main
		int k;
		resetd = 1'b1;
		i_sync = '0;
		i_mode = '0;
		mode_req = '0;
		inv = '0;
		nxt_inv = '0;
		line_len = 32;
		hs_w = 4;
		frame_lines = 10;
		vs_lines = 2;
		cfg_pend = 1'b0;
		gen_on = 1'b0;
		chk_on = 1'b0;
		x = 0;
		y = 0;
		frame_cnt = 0;
		hs_low = 0;
		vs_low = 0;
		serr_cnt = 0;
		rng = 32'd63936;

		// Pins idle through reset and the first cycle after it
		for (k = 0; k < 8; k++) begin
			@(posedge clk);
			#1;
			if (k == 7) begin
				resetd = 1'b0;
			end
			@(negedge clk);
			check_pins(o_vga, '{hs_n: 1'b1, vs_n: 1'b1}, "pins during reset");
		end
		@(negedge clk);
		check_pins(o_vga, '{hs_n: 1'b1, vs_n: 1'b1}, "pins after reset");
		gen_on = 1'b1;

		// Separate syncs in all four polarity combinations
		for (k = 0; k < 4; k++) begin
			new_config(k);
			check_frames(2, "separate sync");
		end

		// Composite with serration
		mode_req.csync_en = 1'b1;
		new_config(2);
		check_frames(3, "composite sync");

		// Disabled output, then back to separate syncs
		mode_req.out_dis = 1'b1;
		wait_frames(1, "output disable");
		check_frames(2, "output disabled");
		mode_req = '0;
		wait_frames(1, "output enable");
		check_frames(2, "separate sync after enable");

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== vga_cfg_pkg.sv ====
// VGA output configuration
// Sync mode selection and the active-low pin bundle

package vga_cfg_pkg;

	// Output mode, static levels
	// csync_en puts composite on the horizontal pin
	// out_dis holds every pin inactive
	typedef struct packed {
		logic csync_en;
		logic out_dis;
	} vga_mode_t;

	// Sync pins as driven to the connector, active low
	typedef struct packed {
		logic hs_n;
		logic vs_n;
	} vga_pins_t;

	// Idle level of the pins
	localparam vga_pins_t PINS_INACTIVE = '{hs_n: 1'b1, vs_n: 1'b1};

endpackage

// ==== vga_sync_out.sv ====
// VGA sync pin stage
// Selects separate or composite sync and drives the pins active low
`timescale 1ns/1ps

module vga_sync_out (
	input  logic                       clk,
	input  logic                       resetd,
	input  sync_types_pkg::sync_pair_t i_sync,
	input  logic                       i_csync,
	input  vga_cfg_pkg::vga_mode_t     i_mode,
	output vga_cfg_pkg::vga_pins_t     o_vga
);

	sync_types_pkg::sync_pair_t sep_d;
	vga_cfg_pkg::vga_pins_t     pins_next;
	vga_cfg_pkg::vga_pins_t     pins_q;

	// Separate syncs wait one cycle for the composite path
	always_ff @(posedge clk) begin
		if (resetd) begin
			sep_d <= sync_types_pkg::SYNC_IDLE;
		end else begin
			sep_d <= i_sync;
		end
	end

	// Mode select
	always_comb begin
		if (i_mode.out_dis) begin
			pins_next = vga_cfg_pkg::PINS_INACTIVE;
		end else if (i_mode.csync_en) begin
			pins_next.hs_n = ~i_csync;
			pins_next.vs_n = 1'b1;
		end else begin
			pins_next.hs_n = ~sep_d.hs;
			pins_next.vs_n = ~sep_d.vs;
		end
	end

	// Pin register, idle high out of reset
	always_ff @(posedge clk) begin
		if (resetd) begin
			pins_q <= vga_cfg_pkg::PINS_INACTIVE;
		end else begin
			pins_q <= pins_next;
		end
	end

	assign o_vga = pins_q;

endmodule

// ==== vga_sync_top.sv ====
// VGA sync conditioning top
// Polarity normalizers, composite generator and pin stage
`timescale 1ns/1ps

module vga_sync_top #(
	parameter int CNT_W = sync_types_pkg::CNT_W_DEFAULT
) (
	input  logic                       clk,
	input  logic                       resetd,
	input  sync_types_pkg::sync_pair_t i_sync,
	input  vga_cfg_pkg::vga_mode_t     i_mode,
	output vga_cfg_pkg::vga_pins_t     o_vga
);

	logic                       hs_norm;
	logic                       vs_norm;
	logic                       csync;
	sync_types_pkg::sync_pair_t norm;

	//////////////////////////////////////////////////////////
	// Polarity normalization
	//////////////////////////////////////////////////////////

	sync_polarity #(
		.CNT_W(CNT_W)
	) hs_pol_i (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.hs),
		.o_sync (hs_norm)
	);

	sync_polarity #(
		.CNT_W(CNT_W)
	) vs_pol_i (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.vs),
		.o_sync (vs_norm)
	);

	assign norm = '{hs: hs_norm, vs: vs_norm};

	//////////////////////////////////////////////////////////
	// Composite and pins
	//////////////////////////////////////////////////////////

	csync_gen #(
		.CNT_W(CNT_W)
	) csync_gen_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_sync  (norm),
		.o_csync (csync)
	);

	vga_sync_out vga_sync_out_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_sync  (norm),
		.i_csync (csync),
		.i_mode  (i_mode),
		.o_vga   (o_vga)
	);

endmodule
